// ==== run_sim.sh ====
#!/bin/sh
# Build and run the DMA testbench with Verilator

LOG=sim.log

verilator --binary --assert --top-module tb_dma_core -f verilog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_dma_core +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
  exit 1
fi
exit 0

// ==== testbench/dma_core_properties.sv ====
`include "dma_cfg.svh"

module dma_core_properties
  import dma_job_pkg::*;
(
  input logic                 clk_i,
  input logic                 rst_n_i,
  input mem_req_t             mem_req_i,
  input mem_rsp_t             mem_rsp_i,
  input dma_job_t             job_i,
  input logic                 job_valid_i,
  input logic                 job_ready_i,
  input logic                 done_i,
  input logic [`DMA_ID_W-1:0] next_id_i,
  input logic [`DMA_ID_W-1:0] done_id_i
);

  int unsigned fail_cnt = 0;
  data_t       last_rdata;
  logic        zero_take;

  assign zero_take = job_valid_i && job_ready_i && (job_i.len == '0);

  always_ff @(posedge clk_i) begin
    if (mem_rsp_i.rvalid) last_rdata <= mem_rsp_i.rdata;
  end

  req_low_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !mem_req_i.req)
    else begin
      fail_cnt++;
      $error("memory request while reset is active");
    end

  wdata_from_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_i.req && mem_req_i.we |-> mem_req_i.wdata == last_rdata)
    else begin
      fail_cnt++;
      $error("write data differs from the last read data");
    end

  done_id_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_id_i <= next_id_i - 32'd1)
    else begin
      fail_cnt++;
      $error("completed id %0d ran ahead of next id %0d", done_id_i, next_id_i);
    end

  // Done in one of the two cycles after a zero-length job is taken
  zero_len_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(zero_take, 2) |-> done_i || $past(done_i))
    else begin
      fail_cnt++;
      $error("zero-length job did not complete in time");
    end

  req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_i.req && !mem_rsp_i.gnt |=> $stable(mem_req_i))
    else begin
      fail_cnt++;
      $error("memory request changed before gnt");
    end

endmodule

bind dma_core_top dma_core_properties i_dma_core_properties (
  .clk_i       ( clk_i     ),
  .rst_n_i     ( rst_n_i   ),
  .mem_req_i   ( mem_req_o ),
  .mem_rsp_i   ( mem_rsp_i ),
  .job_i       ( be_job    ),
  .job_valid_i ( be_valid  ),
  .job_ready_i ( be_ready  ),
  .done_i      ( retire    ),
  .next_id_i   ( next_id   ),
  .done_id_i   ( done_id   )
);

// ==== testbench/tb_dma_core.sv ====
`include "dma_cfg.svh"

module tb_dma_core
  import dma_reg_pkg::*;
  import dma_job_pkg::*;
();

  localparam int unsigned TIMEOUT = 1000;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  reg_req_t    reg_req;
  reg_rsp_t    reg_rsp;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;
  logic [31:0] mem [1024];
  logic [31:0] lcg_state = 32'd4;
  logic [31:0] exp_next = 32'd1;
  logic [31:0] rd_data;
  logic        rd_pending = 1'b0;
  logic        slow_gnt = 1'b0;
  int unsigned gnt_wait = 0;
  int unsigned rd_wait = 0;
  int unsigned req_cycles = 0;
  int unsigned stall_cycles;
  int unsigned test_errs;
  int unsigned prop_base = 0;
  int unsigned tests_run = 0;
  int unsigned failed_tests = 0;
  int unsigned total_errs = 0;

  dma_core_top i_dma_core_top (
    .clk_i     ( clk_i   ),
    .rst_n_i   ( rst_n_i ),
    .reg_req_i ( reg_req ),
    .reg_rsp_o ( reg_rsp ),
    .mem_req_o ( mem_req ),
    .mem_rsp_i ( mem_rsp )
  );

  always #50 clk_i = ~clk_i;

  always @(negedge clk_i) begin
    if (mem_req.req) req_cycles++;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Memory model with random gnt and rvalid delays
  // At most one read in flight
  initial begin
    mem_rsp = '0;
    for (int i = 0; i < 1024; i++) begin
      mem[i] = lcg_next() ^ 32'(i);
    end
    forever begin
      @(posedge clk_i);
      #10;
      mem_rsp.gnt    = 1'b0;
      mem_rsp.rvalid = 1'b0;
      if (rd_pending) begin
        if (rd_wait == 0) begin
          mem_rsp.rvalid = 1'b1;
          mem_rsp.rdata  = rd_data;
          rd_pending     = 1'b0;
        end else begin
          rd_wait--;
        end
      end else if (mem_req.req) begin
        if (gnt_wait == 0) begin
          mem_rsp.gnt = 1'b1;
          if (mem_req.we) begin
            mem[mem_req.addr[9:0]] = mem_req.wdata;
          end else begin
            rd_data    = mem[mem_req.addr[9:0]];
            rd_pending = 1'b1;
            rd_wait    = (lcg_next() >> 16) % 32'd4;
          end
          gnt_wait = (slow_gnt ? 32'd3 : 32'd0) + (lcg_next() >> 16) % 32'd4;
        end else begin
          gnt_wait--;
        end
      end
    end
  end

  task automatic check_eq(input logic [31:0] act, input logic [31:0] exp, input string what);
    assert (act == exp) else begin
      $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, act, exp);
      test_errs++;
    end
  endtask

  // Holds the request until ready and samples at the falling edge
  task automatic reg_access(input logic wr, input reg_idx_t addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    reg_req      = '{valid: 1'b1, write: wr, addr: addr, wdata: wdata};
    stall_cycles = 0;
    @(negedge clk_i);
    while (!reg_rsp.ready && stall_cycles < TIMEOUT) begin
      stall_cycles++;
      @(negedge clk_i);
    end
    if (!reg_rsp.ready) begin
      $display("Register access at offset %0d was never accepted", addr);
      test_errs++;
    end
    rdata = reg_rsp.rdata;
    @(posedge clk_i);
    #10;
    reg_req.valid = 1'b0;
  endtask

  task automatic program_job(input logic [31:0] src, input logic [31:0] dst,
                             input logic [31:0] len);
    logic [31:0] unused;
    reg_access(1'b1, `DMA_REG_SRC, src, unused);
    reg_access(1'b1, `DMA_REG_DST, dst, unused);
    reg_access(1'b1, `DMA_REG_LEN, len, unused);
  endtask

  task automatic launch(output logic [31:0] id);
    reg_access(1'b0, `DMA_REG_NEXT_ID, '0, id);
    check_eq(id, exp_next, "launch id");
    exp_next++;
  endtask

  task automatic wait_done(input logic [31:0] id);
    logic [31:0] rd;
    int unsigned polls;
    polls = 0;
    reg_access(1'b0, `DMA_REG_DONE_ID, '0, rd);
    while (rd != id && polls < TIMEOUT) begin
      polls++;
      reg_access(1'b0, `DMA_REG_DONE_ID, '0, rd);
    end
    if (rd != id) begin
      $display("Completed id stuck at %0d while waiting for %0d", rd, id);
      test_errs++;
    end
  endtask

  task automatic compare_words(input int src, input int dst, input int n);
    for (int i = 0; i < n; i++) begin
      check_eq(mem[10'(dst + i)], mem[10'(src + i)], $sformatf("copied word %0d", i));
    end
  endtask

  task automatic start_test();
    test_errs = 0;
  endtask

  // Assertion failures since the previous test count toward this one
  task automatic end_test(input int num, input string name);
    test_errs += i_dma_core_top.i_dma_core_properties.fail_cnt - prop_base;
    prop_base  = i_dma_core_top.i_dma_core_properties.fail_cnt;
    tests_run++;
    total_errs += test_errs;
    if (test_errs != 0) failed_tests++;
    $display("Test %0d, %s: %0d errors", num, name, test_errs);
  endtask

  initial begin
    logic [31:0] id;
    logic [31:0] rd;
    int unsigned req_base;
    rst_n_i = 1'b0;
    reg_req = '0;
    repeat (10) @(posedge clk_i);
    #10;
    rst_n_i = 1'b1;

    // Length resets to 0, so the first launch is a zero-length job
    start_test();
    check_eq(32'(mem_req.req), 32'd0, "mem req after reset");
    reg_access(1'b0, `DMA_REG_STATUS, '0, rd);
    check_eq(rd, 32'd0, "status after reset");
    reg_access(1'b0, `DMA_REG_DONE_ID, '0, rd);
    check_eq(rd, 32'd0, "done id after reset");
    launch(id);
    wait_done(id);
    end_test(1, "reset values");

    start_test();
    program_job(32'h100, 32'h200, 32'd8);
    launch(id);
    wait_done(id);
    compare_words(32'h100, 32'h200, 8);
    end_test(2, "copy of 8 words");

    start_test();
    program_job(32'h140, 32'h240, 32'd2);
    repeat (3) launch(id);
    wait_done(id);
    compare_words(32'h140, 32'h240, 2);
    end_test(3, "back-to-back launches");

    start_test();
    program_job(32'h180, 32'h280, 32'd0);
    req_base = req_cycles;
    launch(id);
    wait_done(id);
    check_eq(32'(req_cycles - req_base), 32'd0, "memory requests of zero-length job");
    end_test(4, "zero-length job");

    // One job in the backend and two in the FIFO, so the fourth launch stalls
    start_test();
    slow_gnt = 1'b1;
    program_job(32'h1c0, 32'h2c0, 32'd4);
    repeat (3) launch(id);
    launch(id);
    check_eq(32'(stall_cycles != 0), 32'd1, "launch stall with full FIFO");
    reg_access(1'b0, `DMA_REG_STATUS, '0, rd);
    check_eq(rd, 32'd1, "status with jobs queued");
    wait_done(id);
    slow_gnt = 1'b0;
    compare_words(32'h1c0, 32'h2c0, 4);
    end_test(5, "slow grant and full FIFO");

    $display("%0d tests, %0d failed, %0d errors", tests_run, failed_tests, total_errs);
    if (failed_tests == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    #(100 * 50000);
    $display("Simulation did not finish in time");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+verilog
verilog/dma_reg_pkg.sv
verilog/dma_job_pkg.sv
verilog/dma_reg_frontend.sv
verilog/dma_job_fifo.sv
verilog/dma_transfer_id_gen.sv
verilog/dma_backend.sv
verilog/dma_core_top.sv
testbench/dma_core_properties.sv
testbench/tb_dma_core.sv

// ==== verilog/dma_backend.sv ====
`include "dma_cfg.svh"

module dma_backend
  import dma_job_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  dma_job_t job_i,
  input  logic     job_valid_i,
  output logic     job_ready_o,
  output mem_req_t mem_req_o,
  input  mem_rsp_t mem_rsp_i,
  output logic     done_o,
  output logic     idle_o
);

  localparam int unsigned ADDR_W = `DMA_ADDR_W;

  typedef enum logic [2:0] {
    IDLE,
    READ,
    WAIT_DATA,
    WRITE,
    DONE
  } state_e;

  state_e   state_q;
  dma_job_t job_q;
  len_t     word_cnt_q;
  len_t     word_nxt;
  data_t    data_q;
  logic     job_take;

  assign job_ready_o = (state_q == IDLE);
  assign idle_o      = (state_q == IDLE);
  assign done_o      = (state_q == DONE);
  assign job_take    = job_valid_i & job_ready_o;
  assign word_nxt    = word_cnt_q + 1'b1;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= IDLE;
      word_cnt_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (job_take) begin
            word_cnt_q <= '0;
            // Zero-length jobs retire without touching memory
            state_q    <= (job_i.len == '0) ? DONE : READ;
          end
        end
        READ: begin
          if (mem_rsp_i.gnt) state_q <= WAIT_DATA;
        end
        WAIT_DATA: begin
          if (mem_rsp_i.rvalid) state_q <= WRITE;
        end
        WRITE: begin
          if (mem_rsp_i.gnt) begin
            word_cnt_q <= word_nxt;
            state_q    <= (word_nxt == job_q.len) ? DONE : READ;
          end
        end
        DONE: begin
          state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (job_take) begin
      job_q <= job_i;
    end
    if (state_q == WAIT_DATA && mem_rsp_i.rvalid) begin
      data_q <= mem_rsp_i.rdata;
    end
  end

  // Request fields only change on a state change, so they hold until gnt
  always_comb begin
    mem_req_o.req   = (state_q == READ) || (state_q == WRITE);
    mem_req_o.we    = (state_q == WRITE);
    mem_req_o.wdata = data_q;
    if (state_q == WRITE) begin
      mem_req_o.addr = job_q.dst + ADDR_W'(word_cnt_q);
    end else begin
      mem_req_o.addr = job_q.src + ADDR_W'(word_cnt_q);
    end
  end

endmodule

// ==== verilog/dma_cfg.svh ====
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// Memory word address width
`define DMA_ADDR_W 16

// Data and register bus width
`define DMA_DATA_W 32

// Transfer length in words
`define DMA_LEN_W 16

// Transfer id width
`define DMA_ID_W 32

`define DMA_FIFO_DEPTH 2

// Register word offsets
`define DMA_REG_SRC     3'd0
`define DMA_REG_DST     3'd1
`define DMA_REG_LEN     3'd2
`define DMA_REG_STATUS  3'd3
`define DMA_REG_NEXT_ID 3'd4
`define DMA_REG_DONE_ID 3'd5

`endif

// ==== verilog/dma_core_top.sv ====
`include "dma_cfg.svh"

module dma_core_top
  import dma_reg_pkg::*;
  import dma_job_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  output mem_req_t mem_req_o,
  input  mem_rsp_t mem_rsp_i
);

  // Frontend to FIFO
  dma_job_t fe_job;
  logic     fe_valid;
  logic     fe_ready;
  // FIFO to backend
  dma_job_t be_job;
  logic     be_valid;
  logic     be_ready;

  logic                 issue;
  logic                 retire;
  logic [`DMA_ID_W-1:0] next_id;
  logic [`DMA_ID_W-1:0] done_id;
  logic                 fifo_empty;
  logic                 be_idle;
  logic                 busy;

  assign issue = fe_valid & fe_ready;
  assign busy  = ~(fifo_empty & be_idle);

  dma_reg_frontend i_dma_reg_frontend (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .reg_req_i   ( reg_req_i ),
    .reg_rsp_o   ( reg_rsp_o ),
    .job_o       ( fe_job    ),
    .job_valid_o ( fe_valid  ),
    .job_ready_i ( fe_ready  ),
    .next_id_i   ( next_id   ),
    .done_id_i   ( done_id   ),
    .busy_i      ( busy      )
  );

  dma_job_fifo i_dma_job_fifo (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .data_i  ( fe_job     ),
    .valid_i ( fe_valid   ),
    .ready_o ( fe_ready   ),
    .data_o  ( be_job     ),
    .valid_o ( be_valid   ),
    .ready_i ( be_ready   ),
    .empty_o ( fifo_empty )
  );

  dma_transfer_id_gen i_dma_transfer_id_gen (
    .clk_i       ( clk_i   ),
    .rst_n_i     ( rst_n_i ),
    .issue_i     ( issue   ),
    .retire_i    ( retire  ),
    .next_o      ( next_id ),
    .completed_o ( done_id )
  );

  dma_backend i_dma_backend (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .job_i       ( be_job    ),
    .job_valid_i ( be_valid  ),
    .job_ready_o ( be_ready  ),
    .mem_req_o   ( mem_req_o ),
    .mem_rsp_i   ( mem_rsp_i ),
    .done_o      ( retire    ),
    .idle_o      ( be_idle   )
  );

endmodule

// ==== verilog/dma_job_fifo.sv ====
`include "dma_cfg.svh"

module dma_job_fifo
  import dma_job_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  dma_job_t data_i,
  input  logic     valid_i,
  output logic     ready_o,
  output dma_job_t data_o,
  output logic     valid_o,
  input  logic     ready_i,
  output logic     empty_o
);

  localparam int unsigned DEPTH = `DMA_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  dma_job_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign ready_o = (count_q != CNT_W'(DEPTH));
  assign valid_o = (count_q != '0);
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// ==== verilog/dma_job_pkg.sv ====
`include "dma_cfg.svh"

package dma_job_pkg;

  typedef logic [`DMA_ADDR_W-1:0] addr_t;
  typedef logic [`DMA_DATA_W-1:0] data_t;
  typedef logic [`DMA_LEN_W-1:0]  len_t;

  // One copy job in word addresses and a word count
  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  len;
  } dma_job_t;

  // Shared read/write memory port
  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    data_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
  } mem_rsp_t;

endpackage

// ==== verilog/dma_reg_frontend.sv ====
`include "dma_cfg.svh"

module dma_reg_frontend
  import dma_reg_pkg::*;
  import dma_job_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  reg_req_t             reg_req_i,
  output reg_rsp_t             reg_rsp_o,
  output dma_job_t             job_o,
  output logic                 job_valid_o,
  input  logic                 job_ready_i,
  input  logic [`DMA_ID_W-1:0] next_id_i,
  input  logic [`DMA_ID_W-1:0] done_id_i,
  input  logic                 busy_i
);

  localparam int unsigned DATA_W = `DMA_DATA_W;

  logic  launch;
  logic  reg_write;
  addr_t src_q;
  addr_t dst_q;
  len_t  len_q;

  // A read of the next-id register launches the job
  assign launch = reg_req_i.valid & ~reg_req_i.write &
                  (reg_req_i.addr == `DMA_REG_NEXT_ID);

  assign reg_write = reg_req_i.valid & reg_req_i.write;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      src_q <= '0;
      dst_q <= '0;
      len_q <= '0;
    end else if (reg_write) begin
      case (reg_req_i.addr)
        `DMA_REG_SRC: src_q <= reg_req_i.wdata[`DMA_ADDR_W-1:0];
        `DMA_REG_DST: dst_q <= reg_req_i.wdata[`DMA_ADDR_W-1:0];
        `DMA_REG_LEN: len_q <= reg_req_i.wdata[`DMA_LEN_W-1:0];
        default: ;
      endcase
    end
  end

  assign job_o.src   = src_q;
  assign job_o.dst   = dst_q;
  assign job_o.len   = len_q;
  assign job_valid_o = launch;

  // Launch read stalls while the FIFO is full
  assign reg_rsp_o.ready = launch ? job_ready_i : 1'b1;

  always_comb begin
    reg_rsp_o.rdata = '0;
    case (reg_req_i.addr)
      `DMA_REG_SRC: begin
        reg_rsp_o.rdata = DATA_W'(src_q);
      end
      `DMA_REG_DST: begin
        reg_rsp_o.rdata = DATA_W'(dst_q);
      end
      `DMA_REG_LEN: begin
        reg_rsp_o.rdata = DATA_W'(len_q);
      end
      `DMA_REG_STATUS: begin
        reg_rsp_o.rdata = DATA_W'(busy_i);
      end
      `DMA_REG_NEXT_ID: begin
        reg_rsp_o.rdata = DATA_W'(next_id_i);
      end
      `DMA_REG_DONE_ID: begin
        reg_rsp_o.rdata = DATA_W'(done_id_i);
      end
      default: ;
    endcase
  end

endmodule

// ==== verilog/dma_reg_pkg.sv ====
`include "dma_cfg.svh"

package dma_reg_pkg;

  // Word offset into the register file
  typedef logic [2:0] reg_idx_t;

  typedef logic [`DMA_DATA_W-1:0] reg_data_t;

  // Host to DMA
  typedef struct packed {
    logic      valid;
    logic      write;
    reg_idx_t  addr;
    reg_data_t wdata;
  } reg_req_t;

  // DMA to host where ready may stall a launch read
  typedef struct packed {
    logic      ready;
    reg_data_t rdata;
  } reg_rsp_t;

endpackage

// ==== verilog/dma_transfer_id_gen.sv ====
`include "dma_cfg.svh"

module dma_transfer_id_gen (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 issue_i,
  input  logic                 retire_i,
  output logic [`DMA_ID_W-1:0] next_o,
  output logic [`DMA_ID_W-1:0] completed_o
);

  logic [`DMA_ID_W-1:0] next_q;
  logic [`DMA_ID_W-1:0] completed_q;

  // Ids start at 1, so 0 means nothing has completed yet
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      next_q <= `DMA_ID_W'(1);
    end else if (issue_i) begin
      next_q <= next_q + 1'b1;
    end
  end

  // Jobs retire in order
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      completed_q <= '0;
    end else if (retire_i) begin
      completed_q <= completed_q + 1'b1;
    end
  end

  assign next_o      = next_q;
  assign completed_o = completed_q;

endmodule
